// File: compile.f
+incdir+include
source/riscv_priv_pkg.sv
source/irq_pkg.sv
source/irq_arbiter.sv
source/irq_controller.sv
source/irq_dispatch.sv
source/irq_subsys.sv
test/irq_subsys_props.sv
test/irq_subsys_tb.sv

// File: include/irq_params.svh
// sizing macros for the interrupt front end, include wherever line count or id width is needed
`ifndef IRQ_PARAMS_SVH
`define IRQ_PARAMS_SVH

//////////////////////////////////////////////////
// device line sizing
//////////////////////////////////////////////////

// number of level-triggered device lines into the arbiter
// one bit per line in the mask and secure-mask registers
`define IRQ_NUM 32

// width of an interrupt id, enough to index every line
// also sets the vector table stride math in the dispatch
`define IRQ_ID_W 5

//////////////////////////////////////////////////
// derived sizes
//////////////////////////////////////////////////

// trap base and handler vector width
`define IRQ_VEC_W 32

`endif

// File: source/irq_arbiter.sv
// mask registers and fixed-priority pick of the pending device line, feeds the irq controller
`timescale 1ns/1ps
`default_nettype none

`include "irq_params.svh"

module irq_arbiter
  import irq_pkg::*;
(
  input  wire logic                clk,
  input  wire logic                rst_n,
  // configuration write strobe
  input  wire logic                cfg_we_i,
  input  wire logic                cfg_sel_i,
  input  wire logic [`IRQ_NUM-1:0] cfg_wdata_i,
  // level-triggered device lines
  input  wire logic [`IRQ_NUM-1:0] irq_lines_i,
  // selected request toward the controller
  output logic                     irq_pending_o,
  output irq_id_t                  irq_id_o,
  output logic                     irq_sec_o
);

  logic [`IRQ_NUM-1:0] en_mask_q;
  logic [`IRQ_NUM-1:0] sec_mask_q;
  logic [`IRQ_NUM-1:0] active;

  //////////////////////////////////////////////////
  // configuration registers
  //////////////////////////////////////////////////

  // sel 0 targets the enable mask, sel 1 the secure mask
  // both come out of reset fully masked / non-secure
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      en_mask_q  <= '0;
      sec_mask_q <= '0;
    end
    else if (cfg_we_i)
    begin
      if (cfg_sel_i)
        sec_mask_q <= cfg_wdata_i;
      else
        en_mask_q <= cfg_wdata_i;
    end
  end

  //////////////////////////////////////////////////
  // priority selection
  //////////////////////////////////////////////////

  // a line counts only when asserted and enabled
  assign active = irq_lines_i & en_mask_q;

  // scan from the top down so the lowest index wins
  always_comb
  begin
    irq_id_o = '0;
    for (int i = `IRQ_NUM - 1; i >= 0; i--)
    begin
      if (active[i])
        irq_id_o = irq_id_t'(i);
    end
  end

  assign irq_pending_o = |active;
  // secure bit of the winning line, don't care when nothing is pending
  assign irq_sec_o     = sec_mask_q[irq_id_o];

endmodule

`default_nettype wire

// File: source/irq_controller.sv
// request state machine between the arbiter and the dispatch, gates by enables and privilege
`timescale 1ns/1ps
`default_nettype none

module irq_controller
  import irq_pkg::*;
  import riscv_priv_pkg::*;
#(
  parameter bit SECURE_EN = 1'b1
)
(
  input  wire logic  clk,
  input  wire logic  rst_n,
  // selected request from the arbiter
  input  wire logic  irq_pending_i,
  input  irq_id_t    irq_id_i,
  input  wire logic  irq_sec_i,
  // csr state, driven from the core
  input  wire logic  m_ie_i,
  input  wire logic  u_ie_i,
  input  priv_lvl_e  priv_lvl_i,
  // handshake with the dispatch and the core
  input  wire logic  ctrl_ack_i,
  input  wire logic  ctrl_kill_i,
  output logic       irq_req_o,
  output irq_id_t    irq_id_o,
  output logic       irq_sec_o
);

  irq_state_e state_q;
  irq_id_t    id_q;
  logic       sec_q;
  logic       irq_enable;
  logic       capture;

  //////////////////////////////////////////////////
  // enable rule
  //////////////////////////////////////////////////

  // with the secure extension a secure line may interrupt user code
  // even when the user enable is clear
  always_comb
  begin
    if (SECURE_EN)
      irq_enable = ((u_ie_i | irq_sec_i) & (priv_lvl_i == PRIV_LVL_U)) |
                   (m_ie_i & (priv_lvl_i == PRIV_LVL_M));
    else
      irq_enable = m_ie_i;
  end

  // take a new request only from idle
  assign capture = (state_q == IRQ_IDLE) & irq_pending_i & irq_enable;

  //////////////////////////////////////////////////
  // state machine
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q <= IRQ_IDLE;
      sec_q   <= 1'b0;
    end
    else
    begin
      unique case (state_q)
        IRQ_IDLE:
        begin
          if (capture)
          begin
            state_q <= IRQ_PENDING;
            sec_q   <= irq_sec_i;
          end
        end
        IRQ_PENDING:
        begin
          // ack has priority over kill
          if (ctrl_ack_i)
            state_q <= IRQ_DONE;
          else if (ctrl_kill_i)
            state_q <= IRQ_IDLE;
        end
        IRQ_DONE:
        begin
          sec_q   <= 1'b0;
          state_q <= IRQ_IDLE;
        end
        default:
        begin
          state_q <= IRQ_IDLE;
        end
      endcase
    end
  end

  // held id, only meaningful while req is high
  always_ff @(posedge clk)
  begin
    if (capture)
      id_q <= irq_id_i;
  end

  assign irq_req_o = (state_q == IRQ_PENDING);
  assign irq_id_o  = id_q;
  assign irq_sec_o = sec_q;

endmodule

`default_nettype wire

// File: source/irq_dispatch.sv
// handler vector computation and one-entry valid/ready slot from the controller to the core
`timescale 1ns/1ps
`default_nettype none

`include "irq_params.svh"

module irq_dispatch
  import irq_pkg::*;
(
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  // request from the controller
  input  wire logic                  irq_req_i,
  input  irq_id_t                    irq_id_i,
  input  wire logic                  irq_sec_i,
  // trap base from the csr file
  input  wire logic [`IRQ_VEC_W-1:0] mtvec_i,
  output logic                       irq_ack_o,
  // slot toward the core pipeline
  output logic                       irq_valid_o,
  input  wire logic                  irq_ready_i,
  output irq_id_t                    irq_id_o,
  output logic                       irq_sec_o,
  output logic [`IRQ_VEC_W-1:0]      irq_vec_o
);

  logic                  valid_q;
  logic                  load;
  logic [`IRQ_VEC_W-1:0] vec_d;

  //////////////////////////////////////////////////
  // vector computation
  //////////////////////////////////////////////////

  // vectored mode: base aligned to a word, one word per id
  assign vec_d = {mtvec_i[`IRQ_VEC_W-1:2], 2'b00} +
                 {{(`IRQ_VEC_W - `IRQ_ID_W - 2){1'b0}}, irq_id_i, 2'b00};

  //////////////////////////////////////////////////
  // output slot
  //////////////////////////////////////////////////

  // accept when empty or draining in this same cycle
  assign load      = irq_req_i & (~valid_q | irq_ready_i);
  assign irq_ack_o = load;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      valid_q <= 1'b0;
    else if (load)
      valid_q <= 1'b1;
    else if (irq_ready_i)
      valid_q <= 1'b0;
  end

  // payload only moves on a load, so it stays put under back-pressure
  always_ff @(posedge clk)
  begin
    if (load)
    begin
      irq_id_o  <= irq_id_i;
      irq_sec_o <= irq_sec_i;
      irq_vec_o <= vec_d;
    end
  end

  assign irq_valid_o = valid_q;

endmodule

`default_nettype wire

// File: source/irq_pkg.sv
// interrupt id and controller state types, imported by the interrupt front end and its testbench
`default_nettype none

`include "irq_params.svh"

package irq_pkg;

  //////////////////////////////////////////////////
  // interrupt id
  //////////////////////////////////////////////////

  // index of a device line, 0 is the highest priority
  typedef logic [`IRQ_ID_W-1:0] irq_id_t;

  //////////////////////////////////////////////////
  // controller state
  //////////////////////////////////////////////////

  // request holds in pending until ack or kill
  // done is a single cooldown cycle before the next capture
  typedef enum logic [1:0] {
    IRQ_IDLE    = 2'b00,
    IRQ_PENDING = 2'b01,
    IRQ_DONE    = 2'b10
  } irq_state_e;

endpackage

`default_nettype wire

// File: source/irq_subsys.sv
// top of the interrupt front end, wires arbiter, controller and dispatch toward the core
`timescale 1ns/1ps
`default_nettype none

`include "irq_params.svh"

module irq_subsys
  import irq_pkg::*;
  import riscv_priv_pkg::*;
#(
  parameter bit SECURE_EN = 1'b1
)
(
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  // arbiter configuration
  input  wire logic                  cfg_we_i,
  input  wire logic                  cfg_sel_i,
  input  wire logic [`IRQ_NUM-1:0]   cfg_wdata_i,
  // device lines
  input  wire logic [`IRQ_NUM-1:0]   irq_lines_i,
  // csr state and core control
  input  wire logic                  m_ie_i,
  input  wire logic                  u_ie_i,
  input  priv_lvl_e                  priv_lvl_i,
  input  wire logic [`IRQ_VEC_W-1:0] mtvec_i,
  input  wire logic                  kill_i,
  // taken interrupt toward the pipeline
  output logic                       irq_valid_o,
  input  wire logic                  irq_ready_i,
  output irq_id_t                    irq_id_o,
  output logic                       irq_sec_o,
  output logic [`IRQ_VEC_W-1:0]      irq_vec_o
);

  // arbiter to controller
  logic    arb_pending;
  irq_id_t arb_id;
  logic    arb_sec;
  // controller to dispatch
  logic    ctrl_req;
  irq_id_t ctrl_id;
  logic    ctrl_sec;
  logic    disp_ack;

  //////////////////////////////////////////////////
  // decode: line selection
  //////////////////////////////////////////////////

  irq_arbiter u_arbiter (
    .clk           (clk),
    .rst_n         (rst_n),
    .cfg_we_i      (cfg_we_i),
    .cfg_sel_i     (cfg_sel_i),
    .cfg_wdata_i   (cfg_wdata_i),
    .irq_lines_i   (irq_lines_i),
    .irq_pending_o (arb_pending),
    .irq_id_o      (arb_id),
    .irq_sec_o     (arb_sec)
  );

  //////////////////////////////////////////////////
  // execute: request handshake
  //////////////////////////////////////////////////

  irq_controller #(
    .SECURE_EN (SECURE_EN)
  ) u_controller (
    .clk           (clk),
    .rst_n         (rst_n),
    .irq_pending_i (arb_pending),
    .irq_id_i      (arb_id),
    .irq_sec_i     (arb_sec),
    .m_ie_i        (m_ie_i),
    .u_ie_i        (u_ie_i),
    .priv_lvl_i    (priv_lvl_i),
    .ctrl_ack_i    (disp_ack),
    .ctrl_kill_i   (kill_i),
    .irq_req_o     (ctrl_req),
    .irq_id_o      (ctrl_id),
    .irq_sec_o     (ctrl_sec)
  );

  //////////////////////////////////////////////////
  // result: vector and output slot
  //////////////////////////////////////////////////

  irq_dispatch u_dispatch (
    .clk         (clk),
    .rst_n       (rst_n),
    .irq_req_i   (ctrl_req),
    .irq_id_i    (ctrl_id),
    .irq_sec_i   (ctrl_sec),
    .mtvec_i     (mtvec_i),
    .irq_ack_o   (disp_ack),
    .irq_valid_o (irq_valid_o),
    .irq_ready_i (irq_ready_i),
    .irq_id_o    (irq_id_o),
    .irq_sec_o   (irq_sec_o),
    .irq_vec_o   (irq_vec_o)
  );

endmodule

`default_nettype wire

// File: source/riscv_priv_pkg.sv
// privilege level encoding of the core, imported by the controller, the top and the testbench
`default_nettype none

package riscv_priv_pkg;

  //////////////////////////////////////////////////
  // privilege levels
  //////////////////////////////////////////////////

  // encoding follows the mstatus.mpp field
  // supervisor and hypervisor are not implemented on this core
  typedef enum logic [1:0] {
    // user mode
    PRIV_LVL_U = 2'b00,
    // machine mode
    PRIV_LVL_M = 2'b11
  } priv_lvl_e;

endpackage

`default_nettype wire

// File: test/irq_subsys_props.sv
// handshake and output slot assertions, bound into the controller and the dispatch from this file
`timescale 1ns/1ps
`default_nettype none

`include "irq_params.svh"

module irq_subsys_props
  import irq_pkg::*;
(
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  input  wire logic                  req_i,
  input  wire logic                  ack_i,
  input  wire logic                  valid_i,
  input  wire logic                  ready_i,
  input  irq_id_t                    id_i,
  input  wire logic                  sec_i,
  input  wire logic [`IRQ_VEC_W-1:0] vec_i
);

  //////////////////////////////////////////////////
  // controller handshake
  //////////////////////////////////////////////////

  // ack is only legal while a request is held
  a_ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n) ack_i |-> req_i)
    else $error("ack asserted without a pending request");

  // the transfer edge moves the controller out of pending
  a_req_drops_after_ack: assert property (@(posedge clk) disable iff (!rst_n) ack_i |=> !req_i)
    else $error("request still high in the cycle after an ack");

  //////////////////////////////////////////////////
  // held payload
  //////////////////////////////////////////////////

  // payload frozen while the receiver stalls
  a_payload_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (valid_i && !ready_i) |=> (valid_i && $stable(id_i) && $stable(sec_i) && $stable(vec_i)))
    else $error("held payload changed or dropped before it was released");

endmodule

// in the controller the pending request is the held payload
// an ack or a kill releases it, there is no vector on this side
bind irq_controller irq_subsys_props u_ctrl_props (
  .clk     (clk),
  .rst_n   (rst_n),
  .req_i   (irq_req_o),
  .ack_i   (ctrl_ack_i),
  .valid_i (irq_req_o),
  .ready_i (ctrl_ack_i | ctrl_kill_i),
  .id_i    (irq_id_o),
  .sec_i   (irq_sec_o),
  .vec_i   ({`IRQ_VEC_W{1'b0}})
);

bind irq_dispatch irq_subsys_props u_disp_props (
  .clk     (clk),
  .rst_n   (rst_n),
  .req_i   (irq_req_i),
  .ack_i   (irq_ack_o),
  .valid_i (irq_valid_o),
  .ready_i (irq_ready_i),
  .id_i    (irq_id_o),
  .sec_i   (irq_sec_o),
  .vec_i   (irq_vec_o)
);

`default_nettype wire

// File: test/irq_subsys_tb.sv
// self-checking testbench for the interrupt front end, run as top with compile.f
`timescale 1ns/1ps
`default_nettype none

`include "irq_params.svh"

module irq_subsys_tb
  import irq_pkg::*;
  import riscv_priv_pkg::*;
();

  localparam int CLK_PERIOD  = 4;
  localparam int RST_CYCLES  = 8;
  localparam int N_RANDOM    = 30;
  localparam int N_GATE      = 9;
  localparam int N_BP        = 20;
  localparam int N_SCEN      = 1 + N_RANDOM + N_GATE + N_BP + 1;
  localparam int SCEN_BUDGET = 400;
  localparam int WAIT_LIMIT  = 200;
  localparam int QUIET       = 12;

  logic                  clk;
  logic                  rst_n;
  logic                  cfg_we;
  logic                  cfg_sel;
  logic [`IRQ_NUM-1:0]   cfg_wdata;
  logic [`IRQ_NUM-1:0]   irq_lines;
  logic                  m_ie;
  logic                  u_ie;
  priv_lvl_e             priv;
  logic [`IRQ_VEC_W-1:0] mtvec;
  logic                  kill;
  logic                  ready;
  logic                  out_valid;
  irq_id_t               out_id;
  logic                  out_sec;
  logic [`IRQ_VEC_W-1:0] out_vec;

  // mirror of the arbiter mask registers
  logic [`IRQ_NUM-1:0]   en_mask;
  logic [`IRQ_NUM-1:0]   sec_mask;
  // 0 ready high, 1 random, 2 held low
  int                    ready_mode;
  int                    xfer_cnt;
  int                    mismatch_cnt;
  int                    unexpected_cnt;
  int                    missing_cnt;
  irq_id_t               exp_id_q[$];
  logic                  exp_sec_q[$];
  logic [`IRQ_VEC_W-1:0] exp_vec_q[$];

  irq_subsys #(
    .SECURE_EN (1'b1)
  ) DUT (
    .clk         (clk),
    .rst_n       (rst_n),
    .cfg_we_i    (cfg_we),
    .cfg_sel_i   (cfg_sel),
    .cfg_wdata_i (cfg_wdata),
    .irq_lines_i (irq_lines),
    .m_ie_i      (m_ie),
    .u_ie_i      (u_ie),
    .priv_lvl_i  (priv),
    .mtvec_i     (mtvec),
    .kill_i      (kill),
    .irq_valid_o (out_valid),
    .irq_ready_i (ready),
    .irq_id_o    (out_id),
    .irq_sec_o   (out_sec),
    .irq_vec_o   (out_vec)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // budget covers reset plus the worst case of every scenario
  initial
  begin
    #((RST_CYCLES + 10 + N_SCEN * SCEN_BUDGET) * CLK_PERIOD);
    $display("watchdog expired before all scenarios finished");
    $display("Test failed");
    $finish;
  end

  // core side ready, updated off the falling edge
  always @(negedge clk)
  begin
    case (ready_mode)
      0:       ready = 1'b1;
      1:       ready = $urandom % 2;
      default: ready = 1'b0;
    endcase
  end

  //////////////////////////////////////////////////
  // reference model and compare tasks
  //////////////////////////////////////////////////

  // lowest asserted enabled line, then gated by privilege and enables
  function automatic bit expect_irq(input logic [`IRQ_NUM-1:0] lines_v,
                                    input logic [`IRQ_NUM-1:0] en_v,
                                    input logic [`IRQ_NUM-1:0] sec_v,
                                    input logic mie, input logic uie, input priv_lvl_e lvl,
                                    input logic [`IRQ_VEC_W-1:0] base,
                                    output irq_id_t id, output logic sec,
                                    output logic [`IRQ_VEC_W-1:0] vec);
    logic [`IRQ_NUM-1:0] act;
    bit                  found;
    bit                  allowed;
    act   = lines_v & en_v;
    found = 1'b0;
    id    = '0;
    for (int i = 0; i < `IRQ_NUM; i++)
    begin
      if (!found && act[i])
      begin
        found = 1'b1;
        id    = irq_id_t'(i);
      end
    end
    sec = sec_v[id];
    // a secure line may interrupt user code without the user enable
    if (lvl == PRIV_LVL_M)
      allowed = mie;
    else
      allowed = uie || sec;
    vec = (base & 32'hffff_fffc) + (id * 32'd4);
    return found && allowed;
  endfunction

  task automatic check_id(input irq_id_t got, input irq_id_t exp);
    if (got !== exp)
    begin
      $display("MISMATCH at %0t: id got %0d expected %0d", $time, got, exp);
      mismatch_cnt++;
    end
  endtask

  task automatic check_sec(input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("MISMATCH at %0t: secure bit got %b expected %b", $time, got, exp);
      mismatch_cnt++;
    end
  endtask

  task automatic check_vec(input logic [`IRQ_VEC_W-1:0] got, input logic [`IRQ_VEC_W-1:0] exp);
    if (got !== exp)
    begin
      $display("MISMATCH at %0t: vector got %h expected %h", $time, got, exp);
      mismatch_cnt++;
    end
  endtask

  // every accepted output is popped against the expected queue
  always @(posedge clk)
  begin
    if (rst_n && out_valid && ready)
    begin
      xfer_cnt++;
      if (exp_id_q.size() == 0)
      begin
        $display("unexpected output with id %0d at %0t", out_id, $time);
        unexpected_cnt++;
      end
      else
      begin
        check_id(out_id, exp_id_q.pop_front());
        check_sec(out_sec, exp_sec_q.pop_front());
        check_vec(out_vec, exp_vec_q.pop_front());
      end
    end
  end

  //////////////////////////////////////////////////
  // stimulus helpers
  //////////////////////////////////////////////////

  task automatic queue_expected(input irq_id_t id, input logic sec,
                                input logic [`IRQ_VEC_W-1:0] vec);
    exp_id_q.push_back(id);
    exp_sec_q.push_back(sec);
    exp_vec_q.push_back(vec);
  endtask

  task automatic write_cfg(input logic sel, input logic [`IRQ_NUM-1:0] data);
    @(negedge clk);
    cfg_we    = 1'b1;
    cfg_sel   = sel;
    cfg_wdata = data;
    @(negedge clk);
    cfg_we    = 1'b0;
  endtask

  task automatic setup(input logic [`IRQ_NUM-1:0] en, input logic [`IRQ_NUM-1:0] sec,
                       input logic mie, input logic uie, input priv_lvl_e lvl,
                       input logic [`IRQ_VEC_W-1:0] base, input int rmode);
    write_cfg(1'b0, en);
    write_cfg(1'b1, sec);
    en_mask    = en;
    sec_mask   = sec;
    m_ie       = mie;
    u_ie       = uie;
    priv       = lvl;
    mtvec      = base;
    ready_mode = rmode;
  endtask

  task automatic wait_valid(output bit ok);
    ok = 1'b0;
    for (int n = 0; n < WAIT_LIMIT; n++)
    begin
      if (out_valid === 1'b1)
      begin
        ok = 1'b1;
        break;
      end
      @(negedge clk);
    end
  endtask

  task automatic wait_xfer(input int target, output bit ok);
    ok = 1'b0;
    for (int n = 0; n < WAIT_LIMIT; n++)
    begin
      if (xfer_cnt >= target)
      begin
        ok = 1'b1;
        break;
      end
      @(negedge clk);
    end
  endtask

  task automatic report_missing(input irq_id_t id);
    $display("no output arrived for expected id %0d at %0t", id, $time);
    missing_cnt++;
    exp_id_q.delete();
    exp_sec_q.delete();
    exp_vec_q.delete();
    irq_lines = '0;
  endtask

  task automatic check_quiet(input int cycles);
    for (int n = 0; n < cycles; n++)
    begin
      @(negedge clk);
      if (out_valid !== 1'b0)
      begin
        $display("irq_valid_o high at %0t although no interrupt was expected", $time);
        unexpected_cnt++;
        break;
      end
    end
  endtask

  // device model, drops the taken line once its output is in the slot
  task automatic take_one(input irq_id_t id, input int target, output bit ok);
    wait_valid(ok);
    if (ok)
    begin
      irq_lines[id] = 1'b0;
      wait_xfer(target, ok);
    end
  endtask

  //////////////////////////////////////////////////
  // scenarios
  //////////////////////////////////////////////////

  task automatic run_scenario(input logic [`IRQ_NUM-1:0] pattern,
                              input logic [`IRQ_NUM-1:0] en, input logic [`IRQ_NUM-1:0] sec,
                              input logic mie, input logic uie, input priv_lvl_e lvl,
                              input logic [`IRQ_VEC_W-1:0] base, input int rmode);
    irq_id_t               id;
    logic                  sec_b;
    logic [`IRQ_VEC_W-1:0] vec;
    bit                    ok;
    int                    target;
    setup(en, sec, mie, uie, lvl, base, rmode);
    @(negedge clk);
    irq_lines = pattern;
    target    = xfer_cnt;
    // one output per line until the gating leaves nothing to take
    while (expect_irq(irq_lines, en_mask, sec_mask, m_ie, u_ie, priv, mtvec, id, sec_b, vec))
    begin
      queue_expected(id, sec_b, vec);
      target++;
      take_one(id, target, ok);
      if (!ok)
      begin
        report_missing(id);
        break;
      end
    end
    ready_mode = 0;
    check_quiet(QUIET);
    irq_lines = '0;
  endtask

  // old id b is killed behind a full slot, new lower id c must follow a
  task automatic run_kill();
    int                    a;
    int                    b;
    int                    c;
    irq_id_t               id;
    logic                  sec_b;
    logic [`IRQ_VEC_W-1:0] vec;
    bit                    ok;
    int                    target;
    b = 8 + $urandom % 24;
    a = $urandom % b;
    c = $urandom % b;
    if (c == a)
      c = (a + 1) % b;
    setup('1, $urandom, 1'b1, 1'b0, PRIV_LVL_M, $urandom, 2);
    @(negedge clk);
    irq_lines = (32'd1 << a) | (32'd1 << b);
    target    = xfer_cnt;
    void'(expect_irq(irq_lines, en_mask, sec_mask, m_ie, u_ie, priv, mtvec, id, sec_b, vec));
    queue_expected(id, sec_b, vec);
    wait_valid(ok);
    if (!ok)
    begin
      report_missing(id);
      return;
    end
    irq_lines[a] = 1'b0;
    // b gets captured and stalls in pending
    repeat (4) @(negedge clk);
    kill      = 1'b1;
    irq_lines = 32'd1 << c;
    @(negedge clk);
    kill = 1'b0;
    void'(expect_irq(irq_lines, en_mask, sec_mask, m_ie, u_ie, priv, mtvec, id, sec_b, vec));
    queue_expected(id, sec_b, vec);
    ready_mode = 0;
    wait_xfer(target + 1, ok);
    if (ok)
      take_one(id, target + 2, ok);
    if (!ok)
      report_missing(id);
    check_quiet(QUIET);
    irq_lines = '0;
  endtask

  initial
  begin
    int total;
    void'($urandom(45963));
    rst_n          = 1'b0;
    cfg_we         = 1'b0;
    cfg_sel        = 1'b0;
    cfg_wdata      = '0;
    irq_lines      = '0;
    m_ie           = 1'b0;
    u_ie           = 1'b0;
    priv           = PRIV_LVL_M;
    mtvec          = '0;
    kill           = 1'b0;
    ready          = 1'b0;
    ready_mode     = 0;
    en_mask        = '0;
    sec_mask       = '0;
    xfer_cnt       = 0;
    mismatch_cnt   = 0;
    unexpected_cnt = 0;
    missing_cnt    = 0;
    // reset, valid must stay low throughout and after
    check_quiet(RST_CYCLES);
    rst_n = 1'b1;
    check_quiet(10);
    // priority, vector and secure bit in machine mode
    for (int s = 0; s < N_RANDOM; s++)
      run_scenario($urandom & $urandom, $urandom | $urandom, $urandom,
                   1'b1, $urandom % 2, PRIV_LVL_M, $urandom, 0);
    // enable gating: machine enable off, user without and with user enable
    for (int s = 0; s < N_GATE / 3; s++)
    begin
      run_scenario($urandom, '1, $urandom, 1'b0, 1'b1, PRIV_LVL_M, $urandom, 0);
      run_scenario($urandom & $urandom, '1, $urandom, $urandom % 2, 1'b0,
                   PRIV_LVL_U, $urandom, 0);
      run_scenario($urandom & $urandom, $urandom | $urandom, $urandom, $urandom % 2, 1'b1,
                   PRIV_LVL_U, $urandom, 0);
    end
    // back-pressure from a random ready
    for (int s = 0; s < N_BP; s++)
      run_scenario($urandom & $urandom, $urandom | $urandom, $urandom,
                   1'b1, 1'b0, PRIV_LVL_M, $urandom, 1);
    run_kill();
    total = mismatch_cnt + unexpected_cnt + missing_cnt;
    $display("errors: %0d mismatches, %0d unexpected outputs, %0d missing outputs",
             mismatch_cnt, unexpected_cnt, missing_cnt);
    if (total == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire
